//--- wifi_ofdm_pkg.sv
/*
 * OFDM sample and carrier definitions for the 802.11a/g transmit path.
 * Covers the I/Q sample format, the subcarrier numbering and the carrier record
 * that leaves the pilot insertion stage.
 */
`default_nettype none

package wifi_ofdm_pkg;

	localparam int SAMPLE_W      = 16; // Width of one I or Q component, signed
	localparam int CARRIER_IDX_W = 7;  // Signed subcarrier number covers -32 to +31
	localparam int NUM_CARRIERS  = 64; // Subcarriers per OFDM symbol, the IFFT size

	// One complex constellation point in two's complement
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] i; // In-phase part
		logic signed [SAMPLE_W-1:0] q; // Quadrature part
	} ofdm_sample_t;

	typedef logic signed [CARRIER_IDX_W-1:0] carrier_idx_t; // Signed subcarrier number

	// What a subcarrier position carries within the symbol
	typedef enum logic [1:0] {
		CARRIER_NULL  = 2'd0, // Guard band or DC, always zero
		CARRIER_DATA  = 2'd1, // Takes the next modulated input sample
		CARRIER_PILOT = 2'd2  // Real BPSK pilot with scrambled polarity
	} carrier_kind_e;

	// One output carrier as the IFFT loader sees it, 42 bits in all
	typedef struct packed {
		ofdm_sample_t  sample; // Value loaded into the IFFT bin
		carrier_idx_t  index;  // Subcarrier number of this entry
		carrier_kind_e kind;   // Null, data or pilot
		logic          last;   // Marks subcarrier +31 which closes the symbol
	} carrier_t;

endpackage

`default_nettype wire

//--- wifi_pilot_pkg.sv
/*
 * Pilot carrier constants for 802.11a/g legacy OFDM.
 * Pilot positions, their base polarity and the size of the polarity sequence.
 */
`default_nettype none

package wifi_pilot_pkg;

	localparam int PILOT_SEQ_LEN = 127; // Length of the pilot polarity sequence
	localparam int PILOT_ADDR_W  = 7;   // Enough to address all 127 sequence entries
	localparam int NUM_PILOTS    = 4;   // Pilot carriers per symbol
	localparam int USED_MAX      = 26;  // Highest used subcarrier magnitude

	// Pilot subcarrier numbers in ascending order
	localparam logic signed [wifi_ofdm_pkg::CARRIER_IDX_W-1:0] PILOT_POS [0:NUM_PILOTS-1] = '{
		-7'sd21,
		-7'sd7,
		7'sd7,
		7'sd21
	};

	// Base polarity per pilot in the same order as PILOT_POS
	// A set bit means the pilot starts out negative, which is only the +21 carrier
	localparam logic [NUM_PILOTS-1:0] PILOT_BASE_NEG = 4'b1000;

endpackage

`default_nettype wire

//--- wifi_pilot_rom.sv
/*
 * Pilot polarity ROM for 802.11a/g.
 * Returns the 127-entry pilot scrambler sequence bit for a symbol number,
 * combinationally, with bit 1 meaning the pilots of that symbol are inverted.
 */
`timescale 1ns/1ps
`default_nettype none

module wifi_pilot_rom (
	input  logic [wifi_pilot_pkg::PILOT_ADDR_W-1:0] address,
	input  logic                                    read_enable,
	output logic                                    data_out
);

	// Sequence entry n sits at bit n, so the literal reads left to right from entry 0
	localparam logic [0:wifi_pilot_pkg::PILOT_SEQ_LEN-1] POLARITY_SEQ = {
		8'b0000_1110, // Entries 0 to 7
		8'b1111_0010, // Entries 8 to 15
		8'b1100_1001, // Entries 16 to 23
		8'b0000_0010, // Entries 24 to 31
		8'b0010_0110, // Entries 32 to 39
		8'b0010_1110, // Entries 40 to 47
		8'b1011_0110, // Entries 48 to 55
		8'b0000_1100, // Entries 56 to 63
		8'b1101_0100, // Entries 64 to 71
		8'b1110_0111, // Entries 72 to 79
		8'b1011_0100, // Entries 80 to 87
		8'b0010_1010, // Entries 88 to 95
		8'b1111_1010, // Entries 96 to 103
		8'b0101_0001, // Entries 104 to 111
		8'b1011_1000, // Entries 112 to 119
		7'b111_1111   // Entries 120 to 126
	};

	logic addr_in_range; // Address 127 has no entry in the sequence

	assign addr_in_range = (address < wifi_pilot_pkg::PILOT_SEQ_LEN);

	// Output stays low unless a pilot is being read, so the line is quiet elsewhere
	assign data_out = (read_enable && addr_in_range) ? POLARITY_SEQ[address] : 1'b0;

endmodule

`default_nettype wire

//--- wifi_subcarrier_mapper.sv
/*
 * Subcarrier mapper for the 802.11a/g pilot insertion stage.
 * Steps through subcarriers -32 to +31 and fills each with a null, the next
 * data sample or a pilot, into one registered valid/ready output.
 */
`timescale 1ns/1ps
`default_nettype none

module wifi_subcarrier_mapper #(
	parameter logic signed [wifi_ofdm_pkg::SAMPLE_W-1:0] PILOT_AMP = 16'sd8192
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  wifi_ofdm_pkg::ofdm_sample_t             data_in,
	input  logic                                    data_valid,
	output logic                                    data_ready,
	output wifi_ofdm_pkg::carrier_t                 carrier_out,
	output logic                                    out_valid,
	input  logic                                    out_ready,
	output logic [wifi_pilot_pkg::PILOT_ADDR_W-1:0] pilot_addr,
	output logic                                    pilot_rd,
	input  logic                                    pilot_bit
);

	localparam int POS_FIRST = -(wifi_ofdm_pkg::NUM_CARRIERS / 2); // Subcarrier -32
	localparam int POS_LAST  = wifi_ofdm_pkg::NUM_CARRIERS / 2 - 1; // Subcarrier +31
	localparam int SEQ_LAST  = wifi_pilot_pkg::PILOT_SEQ_LEN - 1;   // Last sequence entry

	wifi_ofdm_pkg::carrier_idx_t             pos;          // Subcarrier about to be loaded
	logic [wifi_pilot_pkg::PILOT_ADDR_W-1:0] sym_cnt;      // Symbol number into the sequence
	logic                                    is_null;      // Position is guard band or DC
	logic                                    pilot_hit;    // Position matches a pilot carrier
	logic [1:0]                              pilot_sel;    // Which of the four pilots matched
	wifi_ofdm_pkg::carrier_kind_e            pos_kind;     // Classification of the position
	logic                                    pilot_neg;    // Pilot goes out as -PILOT_AMP
	wifi_ofdm_pkg::carrier_t                 next_carrier; // Entry formed for the position
	logic                                    can_load;     // Register empty or drained now
	logic                                    load;         // Register takes next_carrier

	// Guard bands beyond +-26 and the DC carrier carry nothing
	assign is_null = (pos < -wifi_pilot_pkg::USED_MAX) || (pos > wifi_pilot_pkg::USED_MAX) ||
		(pos == '0);

	// Compare the position against the four pilot carriers
	always_comb begin
		pilot_hit = 1'b0;
		pilot_sel = '0;
		for (int k = 0; k < wifi_pilot_pkg::NUM_PILOTS; k++) begin
			if (pos == wifi_pilot_pkg::PILOT_POS[k]) begin
				pilot_hit = 1'b1;
				pilot_sel = k[1:0]; // Selects the base polarity bit below
			end
		end
	end

	always_comb begin
		if (is_null) begin
			pos_kind = wifi_ofdm_pkg::CARRIER_NULL;
		end else if (pilot_hit) begin
			pos_kind = wifi_ofdm_pkg::CARRIER_PILOT;
		end else begin
			pos_kind = wifi_ofdm_pkg::CARRIER_DATA; // Every other used carrier, 48 per symbol
		end
	end

	// The ROM is read only on pilot positions and answers in the same cycle
	assign pilot_rd   = (pos_kind == wifi_ofdm_pkg::CARRIER_PILOT);
	assign pilot_addr = sym_cnt;

	// Sequence bit flips the base polarity of this pilot carrier
	assign pilot_neg = pilot_bit ^ wifi_pilot_pkg::PILOT_BASE_NEG[pilot_sel];

	// Build the carrier entry for the current position
	always_comb begin
		next_carrier       = '0;
		next_carrier.index = pos;
		next_carrier.kind  = pos_kind;
		next_carrier.last  = (pos == POS_LAST); // Closes the symbol for the IFFT loader
		case (pos_kind)
			wifi_ofdm_pkg::CARRIER_DATA: begin
				next_carrier.sample = data_in; // Modulated sample passes through unchanged
			end
			wifi_ofdm_pkg::CARRIER_PILOT: begin
				next_carrier.sample.i = pilot_neg ? -PILOT_AMP : PILOT_AMP; // Real BPSK pilot
				next_carrier.sample.q = '0;
			end
			default: begin
				next_carrier.sample = '0; // Null carriers are all zero
			end
		endcase
	end

	// The single output register can accept when empty or when it drains this cycle
	assign can_load = !out_valid || out_ready;

	// Input is consumed only on data positions
	assign data_ready = can_load && (pos_kind == wifi_ofdm_pkg::CARRIER_DATA);

	// Nulls and pilots load on their own, data waits for a valid sample
	assign load = can_load && ((pos_kind != wifi_ofdm_pkg::CARRIER_DATA) || data_valid);

	// Position, symbol counter and valid flag
	always_ff @(posedge clk) begin
		if (rst) begin
			pos       <= wifi_ofdm_pkg::CARRIER_IDX_W'(POS_FIRST); // Each symbol starts at -32
			sym_cnt   <= '0;
			out_valid <= 1'b0;
		end else begin
			if (load) begin
				out_valid <= 1'b1;
				if (pos == POS_LAST) begin
					pos <= wifi_ofdm_pkg::CARRIER_IDX_W'(POS_FIRST); // Wrap to the next symbol
					if (sym_cnt == SEQ_LAST) begin
						sym_cnt <= '0; // Sequence repeats after entry 126
					end else begin
						sym_cnt <= sym_cnt + 1'b1;
					end
				end else begin
					pos <= pos + 7'sd1;
				end
			end else if (out_ready) begin
				out_valid <= 1'b0; // Entry taken and no new one ready
			end
		end
	end

	// Payload register follows the load strobe only
	always_ff @(posedge clk) begin
		if (load) begin
			carrier_out <= next_carrier;
		end
	end

endmodule

`default_nettype wire

//--- wifi_pilot_top.sv
/*
 * Pilot insertion stage of an 802.11a/g OFDM transmitter.
 * Joins the subcarrier mapper with the pilot polarity ROM.
 */
`timescale 1ns/1ps
`default_nettype none

module wifi_pilot_top #(
	parameter logic signed [wifi_ofdm_pkg::SAMPLE_W-1:0] PILOT_AMP = 16'sd8192
) (
	input  logic                        clk,
	input  logic                        rst,
	input  wifi_ofdm_pkg::ofdm_sample_t data_in,
	input  logic                        data_valid,
	output logic                        data_ready,
	output wifi_ofdm_pkg::carrier_t     carrier_out,
	output logic                        out_valid,
	input  logic                        out_ready
);

	logic [wifi_pilot_pkg::PILOT_ADDR_W-1:0] pilot_addr; // Symbol number to the ROM
	logic                                    pilot_rd;   // High on pilot positions only
	logic                                    pilot_bit;  // Polarity bit back from the ROM

	wifi_subcarrier_mapper #(
		.PILOT_AMP (PILOT_AMP)
	) u_mapper (
		.clk         (clk),
		.rst         (rst),
		.data_in     (data_in),
		.data_valid  (data_valid),
		.data_ready  (data_ready),
		.carrier_out (carrier_out),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.pilot_addr  (pilot_addr),
		.pilot_rd    (pilot_rd),
		.pilot_bit   (pilot_bit)
	);

	// Combinational lookup keeps the pilot in the same cycle as its position
	wifi_pilot_rom u_pilot_rom (
		.address     (pilot_addr),
		.read_enable (pilot_rd),
		.data_out    (pilot_bit)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Free-running clock plus a synchronous reset pulse at start and on request.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 4.0, // Clock period in ns
	parameter int  RESET_CYCLES = 3    // Rising edges that see reset high
) (
	input  logic restart, // Asks for a fresh reset pulse
	output logic clk,
	output logic rst
);

	int rst_left; // Reset edges still to come

	initial begin
		clk      = 1'b0;
		rst      = 1'b1; // Design starts in reset
		rst_left = RESET_CYCLES;
	end

	always #(PERIOD_NS / 2.0) clk = ~clk;

	always @(posedge clk) begin
		if (restart) begin
			rst      <= 1'b1; // Mid-run reset lasts as long as the first one
			rst_left <= RESET_CYCLES;
		end else if (rst_left != 0) begin
			rst      <= (rst_left > 1);
			rst_left <= rst_left - 1;
		end
	end

endmodule

`default_nettype wire

//--- wifi_pilot_assert.sv
/*
 * Port-level assertions for the pilot insertion top level.
 * Covers reset, output hold under back-pressure and the input handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module wifi_pilot_assert (
	input logic                    clk,
	input logic                    rst,
	input logic                    data_ready,
	input logic                    out_valid,
	input logic                    out_ready,
	input wifi_ofdm_pkg::carrier_t carrier_out
);

	int unsigned fail_count = 0; // Read by the testbench after every cycle

	// Output register comes out of reset empty
	a_idle_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			$error("out_valid high in the cycle after reset");
			fail_count++;
		end

	// A stalled entry keeps its value until the sink takes it
	a_hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(carrier_out)))
		else begin
			$error("carrier_out changed or dropped while stalled");
			fail_count++;
		end

	a_quad_zero: assert property (@(posedge clk) disable iff (rst)
		(out_valid && carrier_out.kind != wifi_ofdm_pkg::CARRIER_DATA) |->
		(carrier_out.sample.q == '0)) // Pilots are real, nulls are zero
		else begin
			$error("pilot or null carrier with nonzero Q");
			fail_count++;
		end

	// Input is only taken when the output register can load
	a_ready_needs_room: assert property (@(posedge clk) disable iff (rst)
		data_ready |-> (!out_valid || out_ready))
		else begin
			$error("data_ready high while the output register is stalled");
			fail_count++;
		end

endmodule

bind wifi_pilot_top wifi_pilot_assert u_assert (
	.clk         (clk),
	.rst         (rst),
	.data_ready  (data_ready),
	.out_valid   (out_valid),
	.out_ready   (out_ready),
	.carrier_out (carrier_out)
);

`default_nettype wire

//--- wifi_pilot_tb.sv
/*
 * Testbench for the 802.11a/g pilot insertion stage.
 * Applies a table of traffic rows and checks every carrier against a model
 * of the subcarrier layout and the pilot scrambler sequence.
 */
`timescale 1ns/1ps
`default_nettype none

module wifi_pilot_tb;

	localparam int TIMEOUT_CYCLES = 200; // Longest quiet stretch allowed on the output
	localparam int NUM_ROWS       = 6;
	localparam int SEQ_LEN        = wifi_pilot_pkg::PILOT_SEQ_LEN;
	localparam logic signed [15:0] PILOT_AMP = 16'sd8192; // Top-level default

	typedef struct packed {
		int   n_out;     // Output transfers in this row
		int   gap_pct;   // Chance in percent that the source idles
		int   stall_pct; // Chance in percent that the sink stalls
		logic reset_end; // Reset in mid-symbol once the row is done
	} test_row_t;

	logic                        clk;
	logic                        rst;
	logic                        restart;
	wifi_ofdm_pkg::ofdm_sample_t data_in;
	logic                        data_valid;
	logic                        data_ready;
	wifi_ofdm_pkg::carrier_t     carrier_out;
	logic                        out_valid;
	logic                        out_ready;

	test_row_t                   rows [NUM_ROWS];
	test_row_t                   row;
	logic                        pilot_seq [SEQ_LEN]; // 1 means the symbol's pilots flip
	wifi_ofdm_pkg::ofdm_sample_t accepted [$];        // Input samples taken, oldest first
	logic [31:0]                 lfsr_state;
	int                          exp_pos;   // Subcarrier expected next
	int                          exp_sym;   // Symbol number modulo the sequence length
	int                          data_seen; // Data carriers so far in this symbol
	logic                        in_taken;  // Input transfer on the coming edge
	logic                        out_taken; // Output transfer on the coming edge

	tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(3)) u_clock (
		.restart (restart),
		.clk     (clk),
		.rst     (rst)
	);

	wifi_pilot_top uut (
		.clk         (clk),
		.rst         (rst),
		.data_in     (data_in),
		.data_valid  (data_valid),
		.data_ready  (data_ready),
		.carrier_out (carrier_out),
		.out_valid   (out_valid),
		.out_ready   (out_ready)
	);

	// Fibonacci LFSR with taps 32 22 2 1, one step per bit
	function automatic logic lfsr_next();
		logic fb;
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			r = {r[30:0], lfsr_next()};
		end
		return r;
	endfunction

	function automatic logic chance(input int pct);
		return take_bits(8) < (pct * 256) / 100; // True with roughly pct percent
	endfunction

	// Scrambler x^7 + x^4 + 1 from all ones gives the pilot polarity sequence
	task automatic build_pilot_seq();
		logic [6:0] s;
		logic       fb;
		s = 7'h7f;
		for (int n = 0; n < SEQ_LEN; n++) begin
			fb           = s[6] ^ s[3];
			s            = {s[5:0], fb};
			pilot_seq[n] = fb;
		end
	endtask

	function automatic wifi_ofdm_pkg::carrier_kind_e kind_of(input int p);
		if (p < -26 || p > 26 || p == 0) begin
			return wifi_ofdm_pkg::CARRIER_NULL; // Guard bands and DC
		end else if (p == -21 || p == -7 || p == 7 || p == 21) begin
			return wifi_ofdm_pkg::CARRIER_PILOT;
		end else begin
			return wifi_ofdm_pkg::CARRIER_DATA;
		end
	endfunction

	task automatic report_fail();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_now(input string why);
		$display("ERROR at time %0t: %s", $time, why);
		report_fail();
	endtask

	task automatic check_sample(input string name, input wifi_ofdm_pkg::ofdm_sample_t got,
		input wifi_ofdm_pkg::ofdm_sample_t exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s got (%0d, %0d) expected (%0d, %0d)", $time, name,
				got.i, got.q, exp.i, exp.q);
			report_fail();
		end
	endtask

	task automatic check_kind(input string name, input wifi_ofdm_pkg::carrier_kind_e got,
		input wifi_ofdm_pkg::carrier_kind_e exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s got %s (%0d) expected %s", $time, name,
				got.name(), got, exp.name());
			report_fail();
		end
	endtask

	task automatic check_index(input string name, input wifi_ofdm_pkg::carrier_idx_t got,
		input wifi_ofdm_pkg::carrier_idx_t exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s got %0d expected %0d", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_last(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s got %b expected %b", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s got %b expected %b", $time, name, got, exp);
			report_fail();
		end
	endtask

	// Predict one output carrier and step the model to the next position
	task automatic check_carrier(input wifi_ofdm_pkg::carrier_t got);
		wifi_ofdm_pkg::carrier_kind_e exp_kind;
		wifi_ofdm_pkg::ofdm_sample_t  exp_sample;
		logic                         neg;
		exp_kind   = kind_of(exp_pos);
		exp_sample = '0;
		if (exp_kind == wifi_ofdm_pkg::CARRIER_DATA) begin
			if (accepted.size() == 0) begin
				fail_now("a data carrier came out with no accepted input sample");
			end else begin
				exp_sample = accepted.pop_front();
			end
			data_seen++;
		end else if (exp_kind == wifi_ofdm_pkg::CARRIER_PILOT) begin
			neg          = (exp_pos == 21) ^ pilot_seq[exp_sym]; // Only +21 starts negative
			exp_sample.i = neg ? -PILOT_AMP : PILOT_AMP;
		end
		check_index("carrier_out.index", got.index, wifi_ofdm_pkg::carrier_idx_t'(exp_pos));
		check_kind("carrier_out.kind", got.kind, exp_kind);
		check_sample("carrier_out.sample", got.sample, exp_sample);
		check_last("carrier_out.last", got.last, exp_pos == 31);
		if (exp_pos == 31) begin
			if (data_seen != 48) begin
				fail_now($sformatf("symbol %0d held %0d data carriers", exp_sym, data_seen));
			end
			data_seen = 0;
			exp_pos   = -32;
			exp_sym   = (exp_sym + 1) % SEQ_LEN; // Wraps back to entry 0 after 126
		end else begin
			exp_pos++;
		end
	endtask

	task automatic restart_model();
		accepted.delete();
		exp_pos   = -32;
		exp_sym   = 0;
		data_seen = 0;
		in_taken  = 1'b0;
	endtask

	// Handshakes are looked at mid-cycle, where every signal is settled
	task automatic sample_cycle();
		@(negedge clk);
		in_taken  = data_valid && data_ready;
		out_taken = out_valid && out_ready;
		if (in_taken && out_valid && !out_ready) begin
			fail_now("an input sample was taken while the output was stalled");
		end
		if (in_taken) begin
			accepted.push_back(data_in);
		end
		if (out_taken) begin
			check_carrier(carrier_out);
		end
		if (uut.u_assert.fail_count != 0) begin
			fail_now("a concurrent assertion on the top-level ports failed");
		end
	endtask

	task automatic drive_cycle(input int gap_pct, input int stall_pct);
		@(posedge clk);
		if (in_taken || !data_valid) begin // Source holds an offered sample until taken
			if (chance(gap_pct)) begin
				data_valid <= 1'b0;
			end else begin
				data_valid <= 1'b1;
				data_in    <= wifi_ofdm_pkg::ofdm_sample_t'(take_bits(32));
			end
		end
		out_ready <= !chance(stall_pct);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 10) begin
				fail_now("reset was never released");
			end
		end
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("data_ready", data_ready, 1'b0);
	endtask

	// Quiet both streams, pulse reset and start the model over at symbol 0
	task automatic apply_reset();
		int n;
		sample_cycle();
		@(posedge clk);
		data_valid <= 1'b0;
		out_ready  <= 1'b0;
		restart    <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		n = 0;
		while (rst !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 10) begin
				fail_now("reset did not assert after the request");
			end
		end
		wait_reset_release();
		restart_model();
	endtask

	initial begin
		int done;
		int idle;
		int cycles;
		lfsr_state = 32'h8472673c;
		restart    = 1'b0;
		data_in    = '0;
		data_valid = 1'b0;
		out_ready  = 1'b0;
		out_taken  = 1'b0;
		rows = '{
			'{64 * 132,    0,  0, 1'b0}, // Full rate across the sequence wrap
			'{64 * 6,     30, 40, 1'b0},
			'{64 + 20,    20, 20, 1'b1}, // Reset inside the second symbol
			'{64 * 3,     10, 25, 1'b0},
			'{64 * 2 + 37, 50, 50, 1'b1},
			'{64 * 2,      0,  0, 1'b0}
		};
		build_pilot_seq();
		restart_model();
		wait_reset_release();
		for (int r = 0; r < NUM_ROWS; r++) begin
			row    = rows[r];
			done   = 0;
			idle   = 0;
			cycles = 0;
			while (done < row.n_out) begin
				sample_cycle();
				drive_cycle(row.gap_pct, row.stall_pct);
				cycles++;
				if (out_taken) begin
					done++;
					idle = 0;
				end else begin
					idle++;
					if (idle > TIMEOUT_CYCLES) begin
						fail_now($sformatf("no output transfer for %0d cycles in row %0d",
							idle, r));
					end
				end
			end
			if (row.gap_pct == 0 && row.stall_pct == 0 && cycles > row.n_out + 2) begin
				fail_now($sformatf("row %0d took %0d cycles, not full rate", r, cycles));
			end
			if (row.reset_end) begin
				apply_reset();
			end
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
wifi_ofdm_pkg.sv
wifi_pilot_pkg.sv
wifi_pilot_rom.sv
wifi_subcarrier_mapper.sv
wifi_pilot_top.sv
tb_clock_gen.sv
wifi_pilot_assert.sv
wifi_pilot_tb.sv

//--- Bender.yml
package:
  name: wifi_pilot_insert

sources:
  # Design, packages first
  - wifi_ofdm_pkg.sv
  - wifi_pilot_pkg.sv
  - wifi_pilot_rom.sv
  - wifi_subcarrier_mapper.sv
  - wifi_pilot_top.sv

  # Testbench
  - target: test
    files:
      - tb_clock_gen.sv
      - wifi_pilot_assert.sv
      - wifi_pilot_tb.sv
